// ==== common/la_decode_pkg.sv ====
package la_decode_pkg;

    // Architectural widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // One-hot ALU operation
    localparam int ALU_OP_W = 12;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // One-hot load kind, {ld_w, ld_b, ld_bu, ld_h, ld_hu}
    localparam int LD_CTRL_W = 5;
    localparam int LD_W      = 4;
    localparam int LD_B      = 3;
    localparam int LD_BU     = 2;
    localparam int LD_H      = 1;
    localparam int LD_HU     = 0;

    // One-hot store kind, {st_w, st_h, st_b}
    localparam int ST_CTRL_W = 3;
    localparam int ST_W      = 2;
    localparam int ST_H      = 1;
    localparam int ST_B      = 0;

    // One-hot branch kind
    localparam int BR_KIND_W = 9;
    localparam int BR_BEQ    = 0;
    localparam int BR_BNE    = 1;
    localparam int BR_BLT    = 2;
    localparam int BR_BGE    = 3;
    localparam int BR_BLTU   = 4;
    localparam int BR_BGEU   = 5;
    localparam int BR_JIRL   = 6;
    localparam int BR_B      = 7;
    localparam int BR_BL     = 8;

    // Link register for bl
    localparam int RA_REG = 1;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg3_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_imm12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_imm16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm;
        logic [4:0]  rd;
    } inst_imm20_t;

    // One instruction word, read through the format that matches its opcode
    typedef union packed {
        inst_reg3_t  reg3;
        inst_imm12_t imm12;
        inst_imm16_t imm16;
        inst_imm20_t imm20;
    } inst_word_t;

endpackage

// ==== decode/inst_decoder.sv ====
module inst_decoder (
    input  la_decode_pkg::inst_word_t                 inst,
    output logic [la_decode_pkg::REG_ADDR_W-1:0]      rf_raddr1,
    output logic [la_decode_pkg::REG_ADDR_W-1:0]      rf_raddr2,
    output logic [la_decode_pkg::ALU_OP_W-1:0]        alu_op,
    output logic                                      src1_is_pc,
    output logic                                      src2_is_imm,
    output logic [la_decode_pkg::XLEN-1:0]            imm,
    output logic [la_decode_pkg::BR_KIND_W-1:0]       br_kind,
    output logic [la_decode_pkg::XLEN-1:0]            br_offs,
    output logic                                      mem_en,
    output logic [la_decode_pkg::LD_CTRL_W-1:0]       ld_ctrl,
    output logic [la_decode_pkg::ST_CTRL_W-1:0]       st_ctrl,
    output logic                                      rf_we,
    output logic [la_decode_pkg::REG_ADDR_W-1:0]      dest,
    output logic                                      ine
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [5:0]  op6;
    logic [6:0]  op7;
    logic [25:0] offs26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_and, inst_nor, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic inst_jirl, inst_b, inst_bl;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;

    logic need_ui5, need_ui12, need_si12, need_si20, src2_is_4;
    logic is_load, is_store, is_cond_br, src_reg_is_rd;

    assign op17 = inst.reg3.opcode;
    assign op10 = inst.imm12.opcode;
    assign op6  = inst.imm16.opcode;
    assign op7  = inst.imm20.opcode;

    // Three-register format, op[31:15]
    assign inst_add_w  = op17 == 17'h00020;
    assign inst_sub_w  = op17 == 17'h00022;
    assign inst_slt    = op17 == 17'h00024;
    assign inst_sltu   = op17 == 17'h00025;
    assign inst_nor    = op17 == 17'h00028;
    assign inst_and    = op17 == 17'h00029;
    assign inst_or     = op17 == 17'h0002a;
    assign inst_xor    = op17 == 17'h0002b;
    assign inst_sll_w  = op17 == 17'h0002e;
    assign inst_srl_w  = op17 == 17'h0002f;
    assign inst_sra_w  = op17 == 17'h00030;
    assign inst_slli_w = op17 == 17'h00081;
    assign inst_srli_w = op17 == 17'h00089;
    assign inst_srai_w = op17 == 17'h00091;

    // 12-bit immediate format, op[31:22]
    assign inst_slti   = op10 == 10'h008;
    assign inst_sltui  = op10 == 10'h009;
    assign inst_addi_w = op10 == 10'h00a;
    assign inst_andi   = op10 == 10'h00d;
    assign inst_ori    = op10 == 10'h00e;
    assign inst_xori   = op10 == 10'h00f;
    assign inst_ld_b   = op10 == 10'h0a0;
    assign inst_ld_h   = op10 == 10'h0a1;
    assign inst_ld_w   = op10 == 10'h0a2;
    assign inst_st_b   = op10 == 10'h0a4;
    assign inst_st_h   = op10 == 10'h0a5;
    assign inst_st_w   = op10 == 10'h0a6;
    assign inst_ld_bu  = op10 == 10'h0a8;
    assign inst_ld_hu  = op10 == 10'h0a9;

    // Branches, op[31:26]
    assign inst_jirl = op6 == 6'h13;
    assign inst_b    = op6 == 6'h14;
    assign inst_bl   = op6 == 6'h15;
    assign inst_beq  = op6 == 6'h16;
    assign inst_bne  = op6 == 6'h17;
    assign inst_blt  = op6 == 6'h18;
    assign inst_bge  = op6 == 6'h19;
    assign inst_bltu = op6 == 6'h1a;
    assign inst_bgeu = op6 == 6'h1b;

    assign inst_lu12i_w   = op7 == 7'h0a;
    assign inst_pcaddu12i = op7 == 7'h0e;

    assign is_load    = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store   = inst_st_b | inst_st_h | inst_st_w;
    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign alu_op[la_decode_pkg::ALU_ADD]  = inst_add_w | inst_addi_w | is_load | is_store
                                           | inst_jirl | inst_bl | inst_pcaddu12i;
    assign alu_op[la_decode_pkg::ALU_SUB]  = inst_sub_w;
    assign alu_op[la_decode_pkg::ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[la_decode_pkg::ALU_SLTU] = inst_sltu | inst_sltui;
    assign alu_op[la_decode_pkg::ALU_AND]  = inst_and | inst_andi;
    assign alu_op[la_decode_pkg::ALU_NOR]  = inst_nor;
    assign alu_op[la_decode_pkg::ALU_OR]   = inst_or | inst_ori;
    assign alu_op[la_decode_pkg::ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[la_decode_pkg::ALU_SLL]  = inst_sll_w | inst_slli_w;
    assign alu_op[la_decode_pkg::ALU_SRL]  = inst_srl_w | inst_srli_w;
    assign alu_op[la_decode_pkg::ALU_SRA]  = inst_sra_w | inst_srai_w;
    assign alu_op[la_decode_pkg::ALU_LUI]  = inst_lu12i_w;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | is_load | is_store;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    // Link value is pc + 4
    assign src2_is_4 = inst_jirl | inst_bl;

    assign imm = {32{src2_is_4}} & 32'd4
               | {32{need_si20}} & {inst.imm20.imm, 12'b0}
               | {32{need_si12}} & {{20{inst.imm12.imm[11]}}, inst.imm12.imm}
               | {32{need_ui5}}  & {27'b0, inst.reg3.rk}
               | {32{need_ui12}} & {20'b0, inst.imm12.imm};

    // offs26 is split across the word, low half in [25:10]
    assign offs26  = {inst.imm16.rj, inst.imm16.rd, inst.imm16.imm};
    assign br_offs = (inst_b | inst_bl) ? {{4{offs26[25]}}, offs26, 2'b0}
                                        : {{14{inst.imm16.imm[15]}}, inst.imm16.imm, 2'b0};

    assign br_kind[la_decode_pkg::BR_BEQ]  = inst_beq;
    assign br_kind[la_decode_pkg::BR_BNE]  = inst_bne;
    assign br_kind[la_decode_pkg::BR_BLT]  = inst_blt;
    assign br_kind[la_decode_pkg::BR_BGE]  = inst_bge;
    assign br_kind[la_decode_pkg::BR_BLTU] = inst_bltu;
    assign br_kind[la_decode_pkg::BR_BGEU] = inst_bgeu;
    assign br_kind[la_decode_pkg::BR_JIRL] = inst_jirl;
    assign br_kind[la_decode_pkg::BR_B]    = inst_b;
    assign br_kind[la_decode_pkg::BR_BL]   = inst_bl;

    assign ld_ctrl[la_decode_pkg::LD_W]  = inst_ld_w;
    assign ld_ctrl[la_decode_pkg::LD_B]  = inst_ld_b;
    assign ld_ctrl[la_decode_pkg::LD_BU] = inst_ld_bu;
    assign ld_ctrl[la_decode_pkg::LD_H]  = inst_ld_h;
    assign ld_ctrl[la_decode_pkg::LD_HU] = inst_ld_hu;

    assign st_ctrl[la_decode_pkg::ST_W] = inst_st_w;
    assign st_ctrl[la_decode_pkg::ST_H] = inst_st_h;
    assign st_ctrl[la_decode_pkg::ST_B] = inst_st_b;

    assign mem_en      = is_load | is_store;
    assign src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
    assign src2_is_imm = need_ui5 | need_ui12 | need_si12 | need_si20 | src2_is_4;

    // Stores and compares take rd as their second source
    assign src_reg_is_rd = is_store | is_cond_br;
    assign rf_raddr1     = inst.reg3.rj;
    assign rf_raddr2     = src_reg_is_rd ? inst.reg3.rd : inst.reg3.rk;

    assign ine = ~(|{alu_op, br_kind});

    assign rf_we = ~(is_store | is_cond_br | inst_b | ine);
    assign dest  = inst_bl ? la_decode_pkg::REG_ADDR_W'(la_decode_pkg::RA_REG) : inst.reg3.rd;

endmodule

// ==== decode/branch_resolver.sv ====
module branch_resolver (
    input  logic [la_decode_pkg::XLEN-1:0]      pc,
    input  logic [la_decode_pkg::XLEN-1:0]      rj_value,
    input  logic [la_decode_pkg::XLEN-1:0]      rkd_value,
    input  logic [la_decode_pkg::BR_KIND_W-1:0] br_kind,
    input  logic [la_decode_pkg::XLEN-1:0]      br_offs,
    output logic                                taken,
    output logic [la_decode_pkg::XLEN-1:0]      target
);

    logic rj_eq_rkd;
    logic rj_lt_rkd_s;
    logic rj_lt_rkd_u;
    logic [la_decode_pkg::XLEN-1:0] target_base;

    assign rj_eq_rkd   = rj_value == rkd_value;
    assign rj_lt_rkd_s = $signed(rj_value) < $signed(rkd_value);
    assign rj_lt_rkd_u = rj_value < rkd_value;

    assign taken = br_kind[la_decode_pkg::BR_BEQ]  &  rj_eq_rkd
                 | br_kind[la_decode_pkg::BR_BNE]  & ~rj_eq_rkd
                 | br_kind[la_decode_pkg::BR_BLT]  &  rj_lt_rkd_s
                 | br_kind[la_decode_pkg::BR_BGE]  & ~rj_lt_rkd_s
                 | br_kind[la_decode_pkg::BR_BLTU] &  rj_lt_rkd_u
                 | br_kind[la_decode_pkg::BR_BGEU] & ~rj_lt_rkd_u
                 | br_kind[la_decode_pkg::BR_JIRL]
                 | br_kind[la_decode_pkg::BR_B]
                 | br_kind[la_decode_pkg::BR_BL];

    // jirl is register-relative, everything else pc-relative
    assign target_base = br_kind[la_decode_pkg::BR_JIRL] ? rj_value : pc;
    assign target      = target_base + br_offs;

endmodule

// ==== src/register_file.sv ====
module register_file (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [la_decode_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [la_decode_pkg::REG_ADDR_W-1:0] raddr2,
    input  logic                                 we,
    input  logic [la_decode_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [la_decode_pkg::XLEN-1:0]       wdata,
    output logic [la_decode_pkg::XLEN-1:0]       rdata1,
    output logic [la_decode_pkg::XLEN-1:0]       rdata2
);

    localparam int NUM_REGS = 2 ** la_decode_pkg::REG_ADDR_W;

    logic [la_decode_pkg::XLEN-1:0] regs [NUM_REGS];

    // r0 reads zero, a write in flight is seen immediately
    function automatic logic [la_decode_pkg::XLEN-1:0] read_port(
        input logic [la_decode_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (we && addr == waddr)
            return wdata;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we && waddr != '0)
        begin
            regs[waddr] <= wdata;
        end
    end

    always_comb
    begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// ==== src/id_stage.sv ====
module id_stage (
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [la_decode_pkg::XLEN-1:0]          in_pc,
    input  la_decode_pkg::inst_word_t               in_inst,

    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [la_decode_pkg::XLEN-1:0]          out_pc,
    output logic [la_decode_pkg::ALU_OP_W-1:0]      out_alu_op,
    output logic [la_decode_pkg::XLEN-1:0]          out_src1,
    output logic [la_decode_pkg::XLEN-1:0]          out_src2,
    output logic [la_decode_pkg::XLEN-1:0]          out_store_data,
    output logic                                    out_mem_en,
    output logic [la_decode_pkg::LD_CTRL_W-1:0]     out_ld_ctrl,
    output logic [la_decode_pkg::ST_CTRL_W-1:0]     out_st_ctrl,
    output logic                                    out_rf_we,
    output logic [la_decode_pkg::REG_ADDR_W-1:0]    out_dest,
    output logic                                    out_ine,

    input  logic                                    wb_we,
    input  logic [la_decode_pkg::REG_ADDR_W-1:0]    wb_addr,
    input  logic [la_decode_pkg::XLEN-1:0]          wb_data,

    output logic                                    br_valid,
    output logic [la_decode_pkg::XLEN-1:0]          br_target
);

    logic [la_decode_pkg::REG_ADDR_W-1:0] rf_raddr1;
    logic [la_decode_pkg::REG_ADDR_W-1:0] rf_raddr2;
    logic [la_decode_pkg::ALU_OP_W-1:0]   alu_op;
    logic                                 src1_is_pc;
    logic                                 src2_is_imm;
    logic [la_decode_pkg::XLEN-1:0]       imm;
    logic [la_decode_pkg::BR_KIND_W-1:0]  br_kind;
    logic [la_decode_pkg::XLEN-1:0]       br_offs;
    logic                                 mem_en;
    logic [la_decode_pkg::LD_CTRL_W-1:0]  ld_ctrl;
    logic [la_decode_pkg::ST_CTRL_W-1:0]  st_ctrl;
    logic                                 rf_we;
    logic [la_decode_pkg::REG_ADDR_W-1:0] dest;
    logic                                 ine;

    logic [la_decode_pkg::XLEN-1:0] rj_value;
    logic [la_decode_pkg::XLEN-1:0] rkd_value;
    logic [la_decode_pkg::XLEN-1:0] src1;
    logic [la_decode_pkg::XLEN-1:0] src2;
    logic                           taken;
    logic [la_decode_pkg::XLEN-1:0] target;
    logic                           accept;

    inst_decoder decoder_inst (
        .inst        (in_inst),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .alu_op      (alu_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .imm         (imm),
        .br_kind     (br_kind),
        .br_offs     (br_offs),
        .mem_en      (mem_en),
        .ld_ctrl     (ld_ctrl),
        .st_ctrl     (st_ctrl),
        .rf_we       (rf_we),
        .dest        (dest),
        .ine         (ine)
    );

    register_file regfile_inst (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    branch_resolver resolver_inst (
        .pc        (in_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_kind   (br_kind),
        .br_offs   (br_offs),
        .taken     (taken),
        .target    (target)
    );

    // Single-entry output register
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    assign src1 = src1_is_pc ? in_pc : rj_value;
    assign src2 = src2_is_imm ? imm : rkd_value;

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else if (accept)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_pc         <= in_pc;
            out_alu_op     <= alu_op;
            out_src1       <= src1;
            out_src2       <= src2;
            out_store_data <= rkd_value;
            out_mem_en     <= mem_en;
            out_ld_ctrl    <= ld_ctrl;
            out_st_ctrl    <= st_ctrl;
            out_rf_we      <= rf_we;
            out_dest       <= dest;
            out_ine        <= ine;
            br_target      <= target;
        end
    end

    // The word accepted right behind a redirect is on the wrong path,
    // so it never raises a second one
    always_ff @(posedge clk)
    begin
        if (reset)
            br_valid <= 1'b0;
        else
            br_valid <= accept && taken && !br_valid;
    end

endmodule

// ==== testbench/id_stage_checker.sv ====
module id_stage_checker (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 in_ready,
    input logic                                 out_valid,
    input logic                                 out_ready,
    input logic [la_decode_pkg::XLEN-1:0]       out_pc,
    input logic [la_decode_pkg::ALU_OP_W-1:0]   out_alu_op,
    input logic [la_decode_pkg::XLEN-1:0]       out_src1,
    input logic [la_decode_pkg::XLEN-1:0]       out_src2,
    input logic [la_decode_pkg::XLEN-1:0]       out_store_data,
    input logic                                 out_mem_en,
    input logic [la_decode_pkg::LD_CTRL_W-1:0]  out_ld_ctrl,
    input logic [la_decode_pkg::ST_CTRL_W-1:0]  out_st_ctrl,
    input logic                                 out_rf_we,
    input logic [la_decode_pkg::REG_ADDR_W-1:0] out_dest,
    input logic                                 out_ine,
    input logic                                 br_valid
);

    localparam int FIELDS_W = 4 * la_decode_pkg::XLEN + la_decode_pkg::ALU_OP_W
                            + la_decode_pkg::LD_CTRL_W + la_decode_pkg::ST_CTRL_W
                            + la_decode_pkg::REG_ADDR_W + 3;

    logic [FIELDS_W-1:0] out_fields;

    assign out_fields = {out_pc, out_alu_op, out_src1, out_src2, out_store_data, out_mem_en,
                         out_ld_ctrl, out_st_ctrl, out_rf_we, out_dest, out_ine};

    // Both valids start low
    empty_after_reset: assert property (@(posedge clk) reset |=> !out_valid && !br_valid)
        else $error("out_valid or br_valid high in the cycle after reset");

    hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_fields))
        else $error("output item changed or dropped while stalled");

    single_redirect: assert property (@(posedge clk) disable iff (reset) br_valid |=> !br_valid)
        else $error("br_valid high in two consecutive cycles");

    ready_rule: assert property (@(posedge clk) disable iff (reset)
        in_ready == (!out_valid || out_ready))
        else $error("in_ready does not follow the output register state");

endmodule

// ==== testbench/id_stage_tb.sv ====
module id_stage_tb;

    localparam logic [31:0] SEED = 32'h2e0b4691;
    localparam int NUM_INSTS    = 2000;
    localparam int MAX_CYCLES   = 20000;
    localparam int DRAIN_CYCLES = 50;

    localparam logic [16:0] REG3_OPS [14] = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29,
        17'h2a, 17'h2b, 17'h2e, 17'h2f, 17'h30, 17'h81, 17'h89, 17'h91};
    localparam int REG3_ALU [14] = '{la_decode_pkg::ALU_ADD, la_decode_pkg::ALU_SUB,
        la_decode_pkg::ALU_SLT, la_decode_pkg::ALU_SLTU, la_decode_pkg::ALU_NOR,
        la_decode_pkg::ALU_AND, la_decode_pkg::ALU_OR, la_decode_pkg::ALU_XOR,
        la_decode_pkg::ALU_SLL, la_decode_pkg::ALU_SRL, la_decode_pkg::ALU_SRA,
        la_decode_pkg::ALU_SLL, la_decode_pkg::ALU_SRL, la_decode_pkg::ALU_SRA};
    // slti sltui addi andi ori xori, then ld.b ld.h ld.w st.b st.h st.w ld.bu ld.hu
    localparam logic [9:0] IMM12_OPS [14] = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e,
        10'h00f, 10'h0a0, 10'h0a1, 10'h0a2, 10'h0a4, 10'h0a5, 10'h0a6, 10'h0a8, 10'h0a9};
    localparam int IMM12_ALU [6] = '{la_decode_pkg::ALU_SLT, la_decode_pkg::ALU_SLTU,
        la_decode_pkg::ALU_ADD, la_decode_pkg::ALU_AND, la_decode_pkg::ALU_OR,
        la_decode_pkg::ALU_XOR};

    typedef struct packed {
        logic [31:0] pc;
        logic [la_decode_pkg::ALU_OP_W-1:0] alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] store_data;
        logic mem_en;
        logic [la_decode_pkg::LD_CTRL_W-1:0] ld_ctrl;
        logic [la_decode_pkg::ST_CTRL_W-1:0] st_ctrl;
        logic rf_we;
        logic [4:0] dest;
        logic ine;
    } expected_t;

    logic clk, reset, in_valid, in_ready, out_valid, out_ready, wb_we, br_valid;
    logic [31:0] in_pc, wb_data, br_target;
    la_decode_pkg::inst_word_t in_inst;
    logic [4:0] wb_addr;
    logic [31:0] out_pc, out_src1, out_src2, out_store_data;
    logic [la_decode_pkg::ALU_OP_W-1:0] out_alu_op;
    logic [la_decode_pkg::LD_CTRL_W-1:0] out_ld_ctrl;
    logic [la_decode_pkg::ST_CTRL_W-1:0] out_st_ctrl;
    logic [4:0] out_dest;
    logic out_mem_en, out_rf_we, out_ine;

    logic [31:0] model_regs [32];
    expected_t   out_queue [$];
    logic [31:0] redirect_queue [$];
    logic        held;
    logic        feeding;
    int          accepted;

    id_stage id_stage_inst (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_pc(in_pc), .in_inst(in_inst),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .out_alu_op(out_alu_op), .out_src1(out_src1), .out_src2(out_src2),
        .out_store_data(out_store_data), .out_mem_en(out_mem_en),
        .out_ld_ctrl(out_ld_ctrl), .out_st_ctrl(out_st_ctrl), .out_rf_we(out_rf_we),
        .out_dest(out_dest), .out_ine(out_ine),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
        .br_valid(br_valid), .br_target(br_target)
    );

    bind id_stage id_stage_checker checker_inst (
        .clk(clk), .reset(reset), .in_ready(in_ready), .out_valid(out_valid),
        .out_ready(out_ready), .out_pc(out_pc), .out_alu_op(out_alu_op),
        .out_src1(out_src1), .out_src2(out_src2), .out_store_data(out_store_data),
        .out_mem_en(out_mem_en), .out_ld_ctrl(out_ld_ctrl), .out_st_ctrl(out_st_ctrl),
        .out_rf_we(out_rf_we), .out_dest(out_dest), .out_ine(out_ine), .br_valid(br_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("ERROR at time %0t: %s", $time, reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    function automatic logic is_kept(input logic [31:0] w);
        for (int i = 0; i < 14; i++)
        begin
            if (w[31:15] == REG3_OPS[i] || w[31:22] == IMM12_OPS[i])
                return 1'b1;
        end
        if (w[31:26] >= 6'h13 && w[31:26] <= 6'h1b)
            return 1'b1;
        return w[31:25] == 7'h0a || w[31:25] == 7'h0e;
    endfunction

    function automatic la_decode_pkg::inst_word_t random_inst();
        la_decode_pkg::inst_word_t u;
        int kind;
        u = $urandom;
        if ($urandom_range(0, 99) < 8)
        begin
            while (is_kept(u))
                u = $urandom;
            return u;
        end
        kind = $urandom_range(0, 38);
        // Few registers, so writebacks often hit the operands
        u.reg3.rd = 5'($urandom_range(0, 7));
        u.reg3.rj = 5'($urandom_range(0, 7));
        if (kind < 11)
            u.reg3.rk = 5'($urandom_range(0, 7));
        if (kind < 14)
            u.reg3.opcode = REG3_OPS[kind];
        else if (kind < 28)
            u.imm12.opcode = IMM12_OPS[kind - 14];
        else if (kind < 37)
            u.imm16.opcode = 6'(kind - 28 + 'h13);
        else
            u.imm20.opcode = (kind == 37) ? 7'h0a : 7'h0e;
        return u;
    endfunction

    function automatic void predict(input logic [31:0] w, input logic [31:0] pc,
                                    output expected_t e, output logic taken,
                                    output logic [31:0] target);
        logic [31:0] vj;
        logic [31:0] vk;
        logic [31:0] vd;
        logic [31:0] offs16;
        logic [31:0] offs26;
        int br;
        vj = model_regs[w[9:5]];
        vk = model_regs[w[14:10]];
        vd = model_regs[w[4:0]];
        offs16 = {{14{w[25]}}, w[25:10], 2'b00};
        offs26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        e = '0;
        e.pc = pc;
        e.src1 = vj;
        e.src2 = vk;
        e.store_data = vk;
        e.dest = w[4:0];
        e.ine = 1'b1;
        taken = 1'b0;
        target = pc + offs16;
        for (int i = 0; i < 14; i++)
        begin
            if (w[31:15] == REG3_OPS[i])
            begin
                e.alu_op[REG3_ALU[i]] = 1'b1;
                e.rf_we = 1'b1;
                e.ine = 1'b0;
                if (i >= 11)
                    e.src2 = {27'b0, w[14:10]};
            end
            if (w[31:22] == IMM12_OPS[i])
            begin
                e.alu_op[(i < 6) ? IMM12_ALU[i] : la_decode_pkg::ALU_ADD] = 1'b1;
                e.rf_we = 1'b1;
                e.ine = 1'b0;
                e.src2 = (i >= 3 && i <= 5) ? {20'b0, w[21:10]} : {{20{w[21]}}, w[21:10]};
                e.mem_en = i >= 6;
                case (i)
                    6: e.ld_ctrl[la_decode_pkg::LD_B] = 1'b1;
                    7: e.ld_ctrl[la_decode_pkg::LD_H] = 1'b1;
                    8: e.ld_ctrl[la_decode_pkg::LD_W] = 1'b1;
                    9: e.st_ctrl[la_decode_pkg::ST_B] = 1'b1;
                    10: e.st_ctrl[la_decode_pkg::ST_H] = 1'b1;
                    11: e.st_ctrl[la_decode_pkg::ST_W] = 1'b1;
                    12: e.ld_ctrl[la_decode_pkg::LD_BU] = 1'b1;
                    13: e.ld_ctrl[la_decode_pkg::LD_HU] = 1'b1;
                    default: ;
                endcase
                if (i >= 9 && i <= 11)
                begin
                    e.rf_we = 1'b0;
                    e.store_data = vd;
                end
            end
        end
        if (w[31:26] >= 6'h13 && w[31:26] <= 6'h1b)
        begin
            br = int'(w[31:26]) - 'h13;
            e.ine = 1'b0;
            taken = 1'b1;
            if (br == 1)
                target = pc + offs26;
            else if (br == 0 || br == 2)
            begin
                // Link value pc + 4, bl links to r1
                e.alu_op[la_decode_pkg::ALU_ADD] = 1'b1;
                e.src1 = pc;
                e.src2 = 32'd4;
                e.rf_we = 1'b1;
                target = (br == 0) ? vj + offs16 : pc + offs26;
                if (br == 2)
                    e.dest = 5'd1;
            end
            else
            begin
                e.src2 = vd;
                e.store_data = vd;
                case (br)
                    3: taken = vj == vd;
                    4: taken = vj != vd;
                    5: taken = $signed(vj) < $signed(vd);
                    6: taken = !($signed(vj) < $signed(vd));
                    7: taken = vj < vd;
                    default: taken = !(vj < vd);
                endcase
            end
        end
        if (w[31:25] == 7'h0a || w[31:25] == 7'h0e)
        begin
            e.ine = 1'b0;
            e.rf_we = 1'b1;
            e.src2 = {w[24:5], 12'b0};
            e.alu_op[(w[31:25] == 7'h0a) ? la_decode_pkg::ALU_LUI : la_decode_pkg::ALU_ADD] = 1'b1;
            if (w[31:25] == 7'h0e)
                e.src1 = pc;
        end
    endfunction

    task automatic compare_item(input expected_t e);
        check_value("out_pc", out_pc, e.pc);
        check_value("out_alu_op", 32'(out_alu_op), 32'(e.alu_op));
        check_value("out_src1", out_src1, e.src1);
        check_value("out_src2", out_src2, e.src2);
        check_value("out_store_data", out_store_data, e.store_data);
        check_value("out_mem_en", 32'(out_mem_en), 32'(e.mem_en));
        check_value("out_ld_ctrl", 32'(out_ld_ctrl), 32'(e.ld_ctrl));
        check_value("out_st_ctrl", 32'(out_st_ctrl), 32'(e.st_ctrl));
        check_value("out_rf_we", 32'(out_rf_we), 32'(e.rf_we));
        check_value("out_dest", 32'(out_dest), 32'(e.dest));
        check_value("out_ine", 32'(out_ine), 32'(e.ine));
    endtask

    task automatic drive_inputs();
        if (!held)
        begin
            in_valid = feeding && $urandom_range(0, 3) != 0;
            in_pc    = $urandom & 32'hffff_fffc;
            in_inst  = random_inst();
        end
        out_ready = !feeding || $urandom_range(0, 3) != 0;
        wb_we     = 1'($urandom_range(0, 1));
        wb_addr   = 5'($urandom_range(0, 7));
        wb_data   = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 3) : $urandom;
    endtask

    // Runs between edges, where every DUT output is settled
    task automatic score_cycle();
        expected_t   e;
        logic        taken;
        logic [31:0] target;
        logic        exp_ready;
        logic        redirect_now;
        redirect_now = 1'b0;
        if (br_valid)
        begin
            if (redirect_queue.size() == 0)
                abort_run("br_valid raised without a taken branch");
            check_value("br_target", br_target, redirect_queue.pop_front());
            redirect_now = 1'b1;
        end
        else if (redirect_queue.size() != 0)
            abort_run("taken branch gave no br_valid pulse");
        check_value("out_valid", 32'(out_valid), 32'(out_queue.size() != 0));
        exp_ready = out_queue.size() == 0 || out_ready;
        check_value("in_ready", 32'(in_ready), 32'(exp_ready));
        if (out_valid && out_ready)
            compare_item(out_queue.pop_front());
        // The coming edge's write is already visible through the bypass
        if (wb_we && wb_addr != 5'd0)
            model_regs[wb_addr] = wb_data;
        if (in_valid && exp_ready)
        begin
            predict(in_inst, in_pc, e, taken, target);
            out_queue.push_back(e);
            // Word right behind a redirect is on the wrong path
            if (taken && !redirect_now)
                redirect_queue.push_back(target);
            accepted++;
        end
        held = in_valid && !exp_ready;
    endtask

    task automatic run_cycle();
        drive_inputs();
        @(negedge clk);
        score_cycle();
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        int cycles;
        void'($urandom(SEED));
        reset = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        out_ready = 1'b0;
        wb_we = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        held = 1'b0;
        feeding = 1'b1;
        accepted = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        cycles = 0;
        while (accepted < NUM_INSTS)
        begin
            if (cycles == MAX_CYCLES)
                abort_run("timed out before all instructions were accepted");
            run_cycle();
            cycles++;
        end

        feeding = 1'b0;
        cycles = 0;
        while (held || out_queue.size() != 0 || redirect_queue.size() != 0)
        begin
            if (cycles == DRAIN_CYCLES)
                abort_run("timed out while draining the output register");
            run_cycle();
            cycles++;
        end
        // Idle cycles catch stray valids
        repeat (3) run_cycle();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
common/la_decode_pkg.sv
decode/inst_decoder.sv
decode/branch_resolver.sv
src/register_file.sv
src/id_stage.sv
testbench/id_stage_checker.sv
testbench/id_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
